/* build.f */
+incdir+include
verilog/isaPkg.sv
verilog/ctrlPkg.sv
verilog/instrDecoder.sv
verilog/ctrlSequencer.sv
verilog/ctrlWordGen.sv
verilog/ctrlUnit.sv
verif/ctrlUnitTb.sv

/* run.sh */
#!/bin/bash
# Compile with Verilator, run, and look for the pass message in the log
cd "$(dirname "$0")" || exit 1
rm -f sim.log

verilator --binary --timing --assert --timescale 1ns/100ps \
    -f build.f --top-module ctrlUnitTb --Mdir obj_dir -o ctrlUnitSim > compile.log 2>&1 \
    && ./obj_dir/ctrlUnitSim > sim.log 2>&1

cat compile.log sim.log 2>/dev/null | tail -n 60

grep -q 'All tests passed!' sim.log 2>/dev/null \
    && echo "Simulation passed" \
    || { echo "Simulation failed, see compile.log and sim.log"; exit 1; }

/* verif/ctrlUnitTb.sv */
`timescale 1ns/100ps
`include "ctrlUnit_cfg.svh"

module ctrlUnitTb;
    import isaPkg::*;
    import ctrlPkg::*;

    localparam int clkPeriod = 40;
    // 4 ALU, 5 shifts, 3 imm/rte, 24 branches, 3 stores, 1 unknown
    localparam int numInstr = 40;
    localparam int watchdogTime = numInstr * 9 * clkPeriod + 20 * clkPeriod;
    localparam int branchRuns = 6;

    logic                 clk = 1'b0;
    logic                 reset;
    logic [`OPCODE_W-1:0] opcode;
    logic [`FUNCT_W-1:0]  funct;
    branchFlags_t         flags;
    ctrlWord_t            ctrlWord;

    logic [15:0] lfsrState;
    ctrlState_t  expPath[$];
    int          testsRun = 0;
    int          testsFailed = 0;
    int          checkCount = 0;
    int          errorCount = 0;

    ctrlUnit UUT (
        .clk      (clk),
        .reset    (reset),
        .opcode   (opcode),
        .funct    (funct),
        .flags    (flags),
        .ctrlWord (ctrlWord)
    );

    always #(clkPeriod / 2) clk = ~clk;

    initial begin
        #(watchdogTime);
        $display("Timeout: the control unit did not finish the instruction list in time");
        $display("Test failures found");
        $finish;
    end

    // x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic [15:0] lfsrNext(input logic [15:0] s);
        lfsrNext = {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    task automatic takeBit(output logic b);
        lfsrState = lfsrNext(lfsrState);
        b = lfsrState[0];
    endtask

    task automatic randomFlags(output branchFlags_t f);
        logic b;
        takeBit(b);
        f.eq = b;
        takeBit(b);
        f.gt = b;
    endtask

    function automatic logic branchCondition(input instrClass_t cls, input branchFlags_t f);
        case (cls)
            clsBeq:  branchCondition = (f.eq == 1'b1);
            clsBne:  branchCondition = (f.eq == 1'b0);
            clsBgt:  branchCondition = (f.gt == 1'b1);
            clsBle:  branchCondition = (f.gt == 1'b0);
            default: branchCondition = 1'b0;
        endcase
    endfunction

    // Reference word for one state, every unlisted field zero
    function automatic ctrlWord_t expectedWord(input ctrlState_t st, input instrClass_t cls,
                                               input branchFlags_t f);
        ctrlWord_t w;
        w = '0;
        case (st)
            stReset: begin
                w.writeEn.regWrite = 1'b1;
                w.muxSel.regDst = regSp;
                w.muxSel.memToReg = memStackInit;
            end
            stFetch1: begin
                w.muxSel.aluSrcB = srcBFour;
                w.opCtrl.aluOp = aluAdd;
            end
            stFetch2: begin
                w.muxSel.aluSrcB = srcBFour;
                w.opCtrl.aluOp = aluAdd;
                w.writeEn.pcWrite = 1'b1;
                w.writeEn.irWrite = 1'b1;
                w.muxSel.pcSource = pcAluResult;
            end
            stDecode: begin
                w.writeEn.abWrite = 1'b1;
                w.writeEn.aluOutWrite = 1'b1;
                w.muxSel.aluSrcB = srcBOffset;
                w.opCtrl.aluOp = aluAdd;
            end
            stAluExec: begin
                w.muxSel.aluSrcA = srcARegA;
                w.writeEn.aluOutWrite = 1'b1;
                if (cls == clsSub) begin
                    w.opCtrl.aluOp = aluSub;
                end else if (cls == clsAnd) begin
                    w.opCtrl.aluOp = aluAnd;
                end else begin
                    w.opCtrl.aluOp = aluAdd;
                end
            end
            stAluWrite: begin
                w.writeEn.regWrite = 1'b1;
                w.muxSel.regDst = regRd;
                w.muxSel.memToReg = memAluOut;
            end
            stImmWrite: begin
                w.writeEn.regWrite = 1'b1;
                w.muxSel.regDst = regRt;
                w.muxSel.memToReg = memAluOut;
            end
            stSlt: begin
                w.writeEn.regWrite = 1'b1;
                w.muxSel.regDst = regRd;
                w.muxSel.aluSrcA = srcARegA;
                w.muxSel.memToReg = memCompare;
                w.opCtrl.aluOp = aluCmp;
            end
            stShiftLoad: begin
                w.opCtrl.shiftOp = shLoad;
                // Register amount for the variable shifts
                if (cls == clsSllv || cls == clsSrav) begin
                    w.muxSel.shiftSrc = shiftSrcA;
                    w.muxSel.shiftAmtSel = amtFromReg;
                end else begin
                    w.muxSel.shiftSrc = shiftSrcB;
                    w.muxSel.shiftAmtSel = amtFromShamt;
                end
            end
            stShiftOp: begin
                if (cls == clsSll || cls == clsSllv) begin
                    w.opCtrl.shiftOp = shLeft;
                end else if (cls == clsSrl) begin
                    w.opCtrl.shiftOp = shRightLogic;
                end else begin
                    w.opCtrl.shiftOp = shRightArith;
                end
            end
            stShiftWrite: begin
                w.writeEn.regWrite = 1'b1;
                w.muxSel.regDst = regRd;
                w.muxSel.memToReg = memShifter;
            end
            stRte: begin
                w.writeEn.pcWrite = 1'b1;
                w.muxSel.pcSource = pcEpc;
            end
            stImmExec: begin
                w.muxSel.aluSrcA = srcARegA;
                w.muxSel.aluSrcB = srcBImm;
                w.opCtrl.aluOp = aluAdd;
                w.writeEn.aluOutWrite = 1'b1;
            end
            stBranchStart, stBranchEnd: begin
                w.muxSel.aluSrcA = srcARegA;
                w.opCtrl.aluOp = aluCmp;
                w.muxSel.pcSource = pcBranchTarget;
                if (st == stBranchEnd) begin
                    w.writeEn.pcWrite = branchCondition(cls, f);
                end
            end
            stStoreAddr, stStoreWait: begin
                w.muxSel.aluSrcA = srcARegA;
                w.muxSel.aluSrcB = srcBImm;
                w.opCtrl.aluOp = aluAdd;
                w.muxSel.iorD = iorData;
                w.writeEn.aluOutWrite = (st == stStoreAddr);
            end
            stStoreData: begin
                w.writeEn.memWrite = 1'b1;
                w.writeEn.mdrWrite = 1'b1;
                w.muxSel.aluSrcA = srcARegA;
                w.muxSel.aluSrcB = srcBImm;
                w.opCtrl.aluOp = aluAdd;
            end
            stStoreWrite: begin
                w.writeEn.memWrite = 1'b1;
                if (cls == clsSh) begin
                    w.opCtrl.storeSize = sizeHalf;
                end else if (cls == clsSb) begin
                    w.opCtrl.storeSize = sizeByte;
                end else begin
                    w.opCtrl.storeSize = sizeWord;
                end
            end
            default: begin
                w = '0;
            end
        endcase
        return w;
    endfunction

    // States from fetch1 to close for one instruction
    task automatic buildStatePath(input instrClass_t cls);
        expPath.delete();
        expPath.push_back(stFetch1);
        expPath.push_back(stFetch2);
        expPath.push_back(stDecode);
        expPath.push_back(stDecode2);
        case (cls)
            clsAdd, clsSub, clsAnd: begin
                expPath.push_back(stAluExec);
                expPath.push_back(stAluWrite);
            end
            clsSlt: expPath.push_back(stSlt);
            clsSll, clsSrl, clsSra, clsSllv, clsSrav: begin
                expPath.push_back(stShiftLoad);
                expPath.push_back(stShiftOp);
                expPath.push_back(stShiftWrite);
            end
            clsRte: expPath.push_back(stRte);
            clsAddi, clsAddiu: begin
                expPath.push_back(stImmExec);
                expPath.push_back(stImmWrite);
            end
            clsBeq, clsBne, clsBgt, clsBle: begin
                expPath.push_back(stBranchStart);
                expPath.push_back(stBranchEnd);
            end
            clsSw, clsSh, clsSb: begin
                expPath.push_back(stStoreAddr);
                expPath.push_back(stStoreWait);
                expPath.push_back(stStoreData);
                expPath.push_back(stStoreWrite);
            end
            default: begin
            end
        endcase
        expPath.push_back(stClose);
    endtask

    task automatic checkWord(input string name, input ctrlWord_t expected);
        checkCount++;
        assert (ctrlWord === expected) else begin
            $display("mismatch in %s: expected %h, actual %h", name, expected, ctrlWord);
            errorCount++;
        end
    endtask

    task automatic reportTest(input string name, input int errorsBefore);
        testsRun++;
        if (errorCount == errorsBefore) begin
            $display("%s: ok", name);
        end else begin
            testsFailed++;
            $display("%s: FAILED with %0d errors", name, errorCount - errorsBefore);
        end
    endtask

    // Called on a falling edge where the next word is fetch1
    task automatic runInstr(input string name, input logic [`OPCODE_W-1:0] op,
                            input logic [`FUNCT_W-1:0] fn, input branchFlags_t f,
                            input instrClass_t cls);
        int errorsBefore;
        errorsBefore = errorCount;
        opcode = op;
        funct = fn;
        flags = f;
        buildStatePath(cls);
        foreach (expPath[i]) begin
            @(negedge clk);
            checkWord(name, expectedWord(expPath[i], cls, f));
        end
        reportTest(name, errorsBefore);
    endtask

    task automatic resetBehavior();
        int errorsBefore;
        errorsBefore = errorCount;
        @(posedge clk);
        repeat (2) begin
            @(negedge clk);
            checkWord("reset", '0);
        end
        reset = 1'b0;
        @(negedge clk);
        checkWord("reset", expectedWord(stReset, clsUnknown, '0));
        reportTest("reset", errorsBefore);
    endtask

    task automatic aluGroup();
        runInstr("add", opRType, fnAdd, '0, clsAdd);
        runInstr("sub", opRType, fnSub, '0, clsSub);
        runInstr("and", opRType, fnAnd, '0, clsAnd);
        runInstr("slt", opRType, fnSlt, '0, clsSlt);
    endtask

    task automatic shiftGroup();
        runInstr("sll", opRType, fnSll, '0, clsSll);
        runInstr("srl", opRType, fnSrl, '0, clsSrl);
        runInstr("sra", opRType, fnSra, '0, clsSra);
        runInstr("sllv", opRType, fnSllv, '0, clsSllv);
        runInstr("srav", opRType, fnSrav, '0, clsSrav);
    endtask

    task automatic immRteGroup();
        runInstr("addi", opAddi, '0, '0, clsAddi);
        runInstr("addiu", opAddiu, '0, '0, clsAddiu);
        runInstr("rte", opRType, fnRte, '0, clsRte);
    endtask

    task automatic branchRunSet(input string base, input logic [`OPCODE_W-1:0] op,
                                input instrClass_t cls);
        branchFlags_t f;
        for (int i = 0; i < branchRuns; i++) begin
            randomFlags(f);
            runInstr($sformatf("%s eq=%0b gt=%0b", base, f.eq, f.gt), op, '0, f, cls);
        end
    endtask

    task automatic branchGroup();
        branchRunSet("beq", opBeq, clsBeq);
        branchRunSet("bne", opBne, clsBne);
        branchRunSet("bgt", opBgt, clsBgt);
        branchRunSet("ble", opBle, clsBle);
    endtask

    task automatic storeGroup();
        runInstr("sw", opSw, '0, '0, clsSw);
        runInstr("sh", opSh, '0, '0, clsSh);
        runInstr("sb", opSb, '0, '0, clsSb);
    endtask

    // Load opcode is not sequenced, so it takes the unknown path
    task automatic unknownOpcode();
        int errorsBefore;
        runInstr("unknown opcode", 6'b100011, '0, '0, clsUnknown);
        errorsBefore = errorCount;
        @(negedge clk);
        checkWord("return to fetch", expectedWord(stFetch1, clsUnknown, '0));
        reportTest("return to fetch", errorsBefore);
    endtask

    initial begin
        reset = 1'b1;
        opcode = '0;
        funct = '0;
        flags = '0;
        lfsrState = 16'd7782;

        resetBehavior();
        aluGroup();
        shiftGroup();
        immRteGroup();
        branchGroup();
        storeGroup();
        unknownOpcode();

        $display("Summary: %0d tests, %0d failed, %0d checks, %0d errors",
                 testsRun, testsFailed, checkCount, errorCount);
        if (errorCount == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

/* verilog/ctrlUnit.sv */
`timescale 1ns/100ps
`include "ctrlUnit_cfg.svh"

module ctrlUnit (
    input  logic                  clk,
    input  logic                  reset,
    input  logic [`OPCODE_W-1:0]  opcode,
    input  logic [`FUNCT_W-1:0]   funct,
    input  ctrlPkg::branchFlags_t flags,
    output ctrlPkg::ctrlWord_t    ctrlWord
);
    import isaPkg::*;
    import ctrlPkg::*;

    instrClass_t instrClass;
    ctrlState_t  state;

    instrDecoder decoder (
        .opcode     (opcode),
        .funct      (funct),
        .instrClass (instrClass)
    );

    ctrlSequencer sequencer (
        .clk        (clk),
        .reset      (reset),
        .instrClass (instrClass),
        .state      (state)
    );

    ctrlWordGen wordGen (
        .clk        (clk),
        .reset      (reset),
        .state      (state),
        .instrClass (instrClass),
        .flags      (flags),
        .ctrlWord   (ctrlWord)
    );

endmodule

/* verilog/ctrlWordGen.sv */
`timescale 1ns/100ps

module ctrlWordGen (
    input  logic                  clk,
    input  logic                  reset,
    input  ctrlPkg::ctrlState_t   state,
    input  isaPkg::instrClass_t   instrClass,
    input  ctrlPkg::branchFlags_t flags,
    output ctrlPkg::ctrlWord_t    ctrlWord
);
    import isaPkg::*;
    import ctrlPkg::*;

    ctrlWord_t word;
    logic      branchTaken;

    always_comb begin
        case (instrClass)
            clsBeq:  branchTaken = flags.eq;
            clsBne:  branchTaken = !flags.eq;
            clsBgt:  branchTaken = flags.gt;
            clsBle:  branchTaken = !flags.gt;
            default: branchTaken = 1'b0;
        endcase
    end

    always_comb begin
        word = '0;
        case (state)
            // Stack pointer init after reset
            stReset: begin
                word.writeEn.regWrite = 1'b1;
                word.muxSel.regDst = regSp;
                word.muxSel.memToReg = memStackInit;
            end
            // PC + 4, written back on the second cycle
            stFetch1, stFetch2: begin
                word.muxSel.aluSrcB = srcBFour;
                word.opCtrl.aluOp = aluAdd;
                if (state == stFetch2) begin
                    word.writeEn.pcWrite = 1'b1;
                    word.writeEn.irWrite = 1'b1;
                    word.muxSel.pcSource = pcAluResult;
                end
            end
            stDecode: begin
                word.writeEn.abWrite = 1'b1;
                word.writeEn.aluOutWrite = 1'b1;
                word.muxSel.aluSrcB = srcBOffset;
                word.opCtrl.aluOp = aluAdd;
            end
            stAluExec: begin
                word.muxSel.aluSrcA = srcARegA;
                word.writeEn.aluOutWrite = 1'b1;
                case (instrClass)
                    clsAdd:  word.opCtrl.aluOp = aluAdd;
                    clsSub:  word.opCtrl.aluOp = aluSub;
                    clsAnd:  word.opCtrl.aluOp = aluAnd;
                    default: word.opCtrl.aluOp = aluNop;
                endcase
            end
            stAluWrite, stImmWrite: begin
                word.writeEn.regWrite = 1'b1;
                word.muxSel.memToReg = memAluOut;
                word.muxSel.regDst = (state == stAluWrite) ? regRd : regRt;
            end
            stSlt: begin
                word.writeEn.regWrite = 1'b1;
                word.muxSel.regDst = regRd;
                word.muxSel.aluSrcA = srcARegA;
                word.muxSel.memToReg = memCompare;
                word.opCtrl.aluOp = aluCmp;
            end
            stShiftLoad: begin
                word.opCtrl.shiftOp = shLoad;
                if (instrClass == clsSllv || instrClass == clsSrav) begin
                    word.muxSel.shiftSrc = shiftSrcA;
                    word.muxSel.shiftAmtSel = amtFromReg;
                end else begin
                    word.muxSel.shiftSrc = shiftSrcB;
                    word.muxSel.shiftAmtSel = amtFromShamt;
                end
            end
            stShiftOp: begin
                case (instrClass)
                    clsSll, clsSllv: word.opCtrl.shiftOp = shLeft;
                    clsSrl:          word.opCtrl.shiftOp = shRightLogic;
                    clsSra, clsSrav: word.opCtrl.shiftOp = shRightArith;
                    default:         word.opCtrl.shiftOp = shNop;
                endcase
            end
            stShiftWrite: begin
                word.writeEn.regWrite = 1'b1;
                word.muxSel.regDst = regRd;
                word.muxSel.memToReg = memShifter;
            end
            stRte: begin
                word.writeEn.pcWrite = 1'b1;
                word.muxSel.pcSource = pcEpc;
            end
            stImmExec: begin
                word.muxSel.aluSrcA = srcARegA;
                word.muxSel.aluSrcB = srcBImm;
                word.opCtrl.aluOp = aluAdd;
                word.writeEn.aluOutWrite = 1'b1;
            end
            // Compare held for two cycles, PC taken on the second
            stBranchStart, stBranchEnd: begin
                word.muxSel.aluSrcA = srcARegA;
                word.opCtrl.aluOp = aluCmp;
                word.muxSel.pcSource = pcBranchTarget;
                word.writeEn.pcWrite = (state == stBranchEnd) && branchTaken;
            end
            stStoreAddr, stStoreWait: begin
                word.muxSel.aluSrcA = srcARegA;
                word.muxSel.aluSrcB = srcBImm;
                word.opCtrl.aluOp = aluAdd;
                word.muxSel.iorD = iorData;
                word.writeEn.aluOutWrite = (state == stStoreAddr);
            end
            stStoreData: begin
                word.writeEn.memWrite = 1'b1;
                word.writeEn.mdrWrite = 1'b1;
                word.muxSel.aluSrcA = srcARegA;
                word.muxSel.aluSrcB = srcBImm;
                word.opCtrl.aluOp = aluAdd;
            end
            stStoreWrite: begin
                word.writeEn.memWrite = 1'b1;
                case (instrClass)
                    clsSh:   word.opCtrl.storeSize = sizeHalf;
                    clsSb:   word.opCtrl.storeSize = sizeByte;
                    default: word.opCtrl.storeSize = sizeWord;
                endcase
            end
            // Decode2 and close drive nothing
            default: begin
                word = '0;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            ctrlWord <= '0;
        end else begin
            ctrlWord <= word;
        end
    end

endmodule

/* verilog/ctrlSequencer.sv */
`timescale 1ns/100ps

module ctrlSequencer (
    input  logic                clk,
    input  logic                reset,
    input  isaPkg::instrClass_t instrClass,
    output ctrlPkg::ctrlState_t state
);
    import isaPkg::*;
    import ctrlPkg::*;

    ctrlState_t nextState;

    always_comb begin
        case (state)
            stReset: begin
                nextState = stFetch1;
            end
            stFetch1: begin
                nextState = stFetch2;
            end
            stFetch2: begin
                nextState = stDecode;
            end
            stDecode: begin
                nextState = stDecode2;
            end
            // Dispatch on the decoded class
            stDecode2: begin
                case (instrClass)
                    clsAdd, clsSub, clsAnd: begin
                        nextState = stAluExec;
                    end
                    clsSlt: begin
                        nextState = stSlt;
                    end
                    clsSll, clsSrl, clsSra, clsSllv, clsSrav: begin
                        nextState = stShiftLoad;
                    end
                    clsRte: begin
                        nextState = stRte;
                    end
                    clsAddi, clsAddiu: begin
                        nextState = stImmExec;
                    end
                    clsBeq, clsBne, clsBgt, clsBle: begin
                        nextState = stBranchStart;
                    end
                    clsSw, clsSh, clsSb: begin
                        nextState = stStoreAddr;
                    end
                    default: begin
                        nextState = stClose;
                    end
                endcase
            end
            stAluExec: begin
                nextState = stAluWrite;
            end
            stShiftLoad: begin
                nextState = stShiftOp;
            end
            stShiftOp: begin
                nextState = stShiftWrite;
            end
            stImmExec: begin
                nextState = stImmWrite;
            end
            stBranchStart: begin
                nextState = stBranchEnd;
            end
            stStoreAddr: begin
                nextState = stStoreWait;
            end
            stStoreWait: begin
                nextState = stStoreData;
            end
            stStoreData: begin
                nextState = stStoreWrite;
            end
            stClose: begin
                nextState = stFetch1;
            end
            // Last state of every execute path
            default: begin
                nextState = stClose;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= stReset;
        end else begin
            state <= nextState;
        end
    end

endmodule

/* verilog/instrDecoder.sv */
`timescale 1ns/100ps
`include "ctrlUnit_cfg.svh"

module instrDecoder (
    input  logic [`OPCODE_W-1:0] opcode,
    input  logic [`FUNCT_W-1:0]  funct,
    output isaPkg::instrClass_t  instrClass
);
    import isaPkg::*;

    always_comb begin
        instrClass = clsUnknown;
        case (opcode)
            // R-type work is picked by funct
            opRType: begin
                case (funct)
                    fnAdd: begin
                        instrClass = clsAdd;
                    end
                    fnSub: begin
                        instrClass = clsSub;
                    end
                    fnAnd: begin
                        instrClass = clsAnd;
                    end
                    fnSlt: begin
                        instrClass = clsSlt;
                    end
                    fnSll: begin
                        instrClass = clsSll;
                    end
                    fnSrl: begin
                        instrClass = clsSrl;
                    end
                    fnSra: begin
                        instrClass = clsSra;
                    end
                    fnSllv: begin
                        instrClass = clsSllv;
                    end
                    fnSrav: begin
                        instrClass = clsSrav;
                    end
                    fnRte: begin
                        instrClass = clsRte;
                    end
                    default: begin
                        instrClass = clsUnknown;
                    end
                endcase
            end
            opAddi:  instrClass = clsAddi;
            opAddiu: instrClass = clsAddiu;
            opBeq:   instrClass = clsBeq;
            opBne:   instrClass = clsBne;
            opBgt:   instrClass = clsBgt;
            opBle:   instrClass = clsBle;
            opSw:    instrClass = clsSw;
            opSh:    instrClass = clsSh;
            opSb:    instrClass = clsSb;
            default: instrClass = clsUnknown;
        endcase
    end

endmodule

/* verilog/ctrlPkg.sv */
`include "ctrlUnit_cfg.svh"

package ctrlPkg;

    typedef enum logic [4:0] {
        stReset,
        stFetch1,
        stFetch2,
        stDecode,
        stDecode2,
        stAluExec,
        stAluWrite,
        stSlt,
        stShiftLoad,
        stShiftOp,
        stShiftWrite,
        stRte,
        stImmExec,
        stImmWrite,
        stBranchStart,
        stBranchEnd,
        stStoreAddr,
        stStoreWait,
        stStoreData,
        stStoreWrite,
        stClose
    } ctrlState_t;

    typedef enum logic [`ALUOP_W-1:0] {
        aluNop = 3'd0,
        aluAdd = 3'd1,
        aluSub = 3'd2,
        aluAnd = 3'd3,
        aluCmp = 3'd7
    } aluOp_t;

    typedef enum logic [`SHIFTOP_W-1:0] {
        shNop        = 3'd0,
        shLoad       = 3'd1,
        shLeft       = 3'd2,
        shRightLogic = 3'd3,
        shRightArith = 3'd4
    } shiftOp_t;

    typedef enum logic [`SEL_W-1:0] {sizeWord = 2'd0, sizeByte = 2'd1, sizeHalf = 2'd2} storeSize_t;

    typedef enum logic [`SEL_W-1:0] {regRt = 2'd0, regRd = 2'd1, regSp = 2'd2} regDst_t;

    typedef enum logic [`MEMTOREG_W-1:0] {
        memAluOut    = 4'd5,
        memShifter   = 4'd6,
        memCompare   = 4'd7,
        memStackInit = 4'd8
    } memToReg_t;

    // Next PC source
    typedef enum logic [`SEL_W-1:0] {
        pcAluOutReg    = 2'd0,
        pcEpc          = 2'd1,
        pcAluResult    = 2'd2,
        pcBranchTarget = 2'd3
    } pcSrc_t;

    // ALU B operand
    typedef enum logic [`SEL_W-1:0] {
        srcBReg    = 2'd0,
        srcBFour   = 2'd1,
        srcBOffset = 2'd2,
        srcBImm    = 2'd3
    } aluSrcB_t;

    // Single-bit selects
    localparam logic iorData      = 1'b1;
    localparam logic srcARegA     = 1'b1;
    localparam logic amtFromShamt = 1'b1;
    localparam logic amtFromReg   = 1'b0;
    localparam logic shiftSrcB    = 1'b1;
    localparam logic shiftSrcA    = 1'b0;

    typedef struct packed {
        logic eq;
        logic gt;
    } branchFlags_t;

    typedef struct packed {
        logic pcWrite;
        logic memWrite;
        logic irWrite;
        logic abWrite;
        logic regWrite;
        logic aluOutWrite;
        logic mdrWrite;
    } writeEn_t;

    typedef struct packed {
        regDst_t   regDst;
        logic      iorD;
        pcSrc_t    pcSource;
        logic      shiftAmtSel;
        logic      shiftSrc;
        logic      aluSrcA;
        aluSrcB_t  aluSrcB;
        memToReg_t memToReg;
    } muxSel_t;

    typedef struct packed {
        aluOp_t     aluOp;
        shiftOp_t   shiftOp;
        storeSize_t storeSize;
    } opCtrl_t;

    typedef struct packed {
        writeEn_t writeEn;
        muxSel_t  muxSel;
        opCtrl_t  opCtrl;
    } ctrlWord_t;

endpackage

/* verilog/isaPkg.sv */
`include "ctrlUnit_cfg.svh"

package isaPkg;

    // Opcodes, zero is the R-type group
    localparam logic [`OPCODE_W-1:0] opRType = 6'b000000;
    localparam logic [`OPCODE_W-1:0] opAddi  = 6'b001000;
    localparam logic [`OPCODE_W-1:0] opAddiu = 6'b001001;
    localparam logic [`OPCODE_W-1:0] opBeq   = 6'b000100;
    localparam logic [`OPCODE_W-1:0] opBne   = 6'b000101;
    localparam logic [`OPCODE_W-1:0] opBle   = 6'b000110;
    localparam logic [`OPCODE_W-1:0] opBgt   = 6'b000111;
    localparam logic [`OPCODE_W-1:0] opSb    = 6'b101000;
    localparam logic [`OPCODE_W-1:0] opSh    = 6'b101001;
    localparam logic [`OPCODE_W-1:0] opSw    = 6'b101011;

    // R-type funct codes
    localparam logic [`FUNCT_W-1:0] fnAdd  = 6'b100000;
    localparam logic [`FUNCT_W-1:0] fnSub  = 6'b100010;
    localparam logic [`FUNCT_W-1:0] fnAnd  = 6'b100100;
    localparam logic [`FUNCT_W-1:0] fnSll  = 6'b000000;
    localparam logic [`FUNCT_W-1:0] fnSllv = 6'b000100;
    localparam logic [`FUNCT_W-1:0] fnSra  = 6'b000011;
    localparam logic [`FUNCT_W-1:0] fnSrav = 6'b000111;
    localparam logic [`FUNCT_W-1:0] fnSrl  = 6'b000010;
    localparam logic [`FUNCT_W-1:0] fnSlt  = 6'b101010;
    localparam logic [`FUNCT_W-1:0] fnRte  = 6'b010011;

    typedef enum logic [4:0] {
        clsAdd,
        clsSub,
        clsAnd,
        clsSlt,
        clsSll,
        clsSrl,
        clsSra,
        clsSllv,
        clsSrav,
        clsRte,
        clsAddi,
        clsAddiu,
        clsBeq,
        clsBne,
        clsBgt,
        clsBle,
        clsSw,
        clsSh,
        clsSb,
        clsUnknown
    } instrClass_t;

endpackage

/* include/ctrlUnit_cfg.svh */
`ifndef CTRLUNIT_CFG_SVH
`define CTRLUNIT_CFG_SVH

// Instruction fields
`define OPCODE_W 6
`define FUNCT_W 6

// Control word operation fields
`define ALUOP_W 3
`define SHIFTOP_W 3

// Register write data source
`define MEMTOREG_W 4

// Two-bit multiplexer selects
`define SEL_W 2

`endif
